// ==== Bender.yml ====
package:
  name: minimig_core

sources:
  - chipbus_pkg.sv
  - cia_bus_if.sv
  - cpu_bus_bridge.sv
  - address_decoder.sv
  - cia_timer_port.sv
  - chip_ram.sv
  - bus_read_merge.sv
  - minimig_core.sv
  - target: simulation
    files:
      - minimig_core_sva.sv
      - tb_minimig_core.sv

// ==== address_decoder.sv ====
/*
 * address decoder for chip ram and the cia register space
 * per-cia selects on their byte lanes, kickstart overlay flag
 */
`default_nettype none

module address_decoder #(
	parameter  int CHIP_WORDS = 256,
	parameter  int NUM_CIA    = chipbus_pkg::NUM_CIA,
	localparam int RAM_AW     = $clog2(CHIP_WORDS)
) (
	input  logic               clk,
	input  logic               reset,
	input  chipbus_pkg::addr_t address,
	input  chipbus_pkg::data_t wdata,
	input  logic               strobe,
	input  logic               wr,
	input  logic [1:0]         byte_en,
	output logic               cia_cycle,
	output logic               ram_en,
	output logic               ram_we,
	output logic [RAM_AW-1:0]  ram_addr,
	output logic [1:0]         ram_be,
	cia_bus_if.decoder         cia [NUM_CIA],
	output logic               ovl
);
	import chipbus_pkg::*;

	logic               chip_hit;
	logic [NUM_CIA-1:0] cia_region;
	logic [NUM_CIA-1:0] cia_sel;

	// -------------------- chip ram
	assign chip_hit = (address[23:20] <= CHIP_LIMIT);
	assign ram_en   = strobe & chip_hit;
	assign ram_we   = wr;
	assign ram_addr = address[RAM_AW:1];	// small ram mirrors through the region
	assign ram_be   = byte_en;

	// -------------------- cia space
	for (genvar i = 0; i < NUM_CIA; i++) begin : g_cia
		localparam int LANE = cia_lane(i);

		assign cia_region[i] = (address[23:12] == cia_base(i));
		assign cia_sel[i]    = strobe & cia_region[i] & byte_en[LANE];	// lane strobe must match

		assign cia[i].sel   = cia_sel[i];
		assign cia[i].wr    = wr;
		assign cia[i].rs    = address[11:8];	// register number
		assign cia[i].wdata = wdata[LANE*8 +: 8];
	end

	// bridge waits for the e clock on any cia region address
	assign cia_cycle = |cia_region;

	// overlay set at reset, first write to cia a drops it
	always_ff @(posedge clk) begin
		if (reset)
			ovl <= 1'b1;
		else if (cia_sel[0] & wr)
			ovl <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== bus_read_merge.sv ====
/*
 * cpu read data merge from chip ram and the cia lanes
 * interrupt level encoding
 */
`default_nettype none

module bus_read_merge #(
	parameter int NUM_CIA = chipbus_pkg::NUM_CIA
) (
	cia_bus_if.merge           cias [NUM_CIA],
	input  chipbus_pkg::data_t ram_rdata,
	input  logic               ram_sel,	// last read came from chip ram
	output chipbus_pkg::data_t cpu_data,
	output logic [2:0]         cpu_ipl
);
	import chipbus_pkg::*;

	data_t              cia_lanes [NUM_CIA];
	logic [NUM_CIA-1:0] cia_irq;
	data_t              cia_data;

	for (genvar i = 0; i < NUM_CIA; i++) begin : g_lane
		assign cia_lanes[i] = data_t'(cias[i].rdata) << (8 * cia_lane(i));	// onto own lane
		assign cia_irq[i]   = cias[i].irq;
	end

	always_comb begin
		cia_data = '0;
		for (int i = 0; i < NUM_CIA; i++)
			cia_data = cia_data | cia_lanes[i];
	end

	// cia lanes only show while no ram read owns the bus
	assign cpu_data = ({16{ram_sel}} & ram_rdata) | ({16{~ram_sel}} & cia_data);

	// highest pending level wins, cia b over cia a
	always_comb begin
		cpu_ipl = 3'd0;
		for (int i = 0; i < NUM_CIA; i++)
			if (cia_irq[i] && cia_ipl(i) > cpu_ipl)
				cpu_ipl = cia_ipl(i);
	end

endmodule

`default_nettype wire

// ==== chip_ram.sv ====
/*
 * chip ram, one word wide, registered read, byte lane writes
 */
`default_nettype none

module chip_ram #(
	parameter  int CHIP_WORDS = 256,
	localparam int RAM_AW     = $clog2(CHIP_WORDS)
) (
	input  logic               clk,
	input  logic               en,
	input  logic               we,
	input  logic [1:0]         be,	// [1] high byte
	input  logic [RAM_AW-1:0]  addr,
	input  chipbus_pkg::data_t wdata,
	output chipbus_pkg::data_t rdata
);
	import chipbus_pkg::*;

	data_t mem [CHIP_WORDS];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				if (be[0])
					mem[addr][7:0] <= wdata[7:0];
				if (be[1])
					mem[addr][15:8] <= wdata[15:8];
			end else begin
				rdata <= mem[addr];	// held until the next read
			end
		end
	end

endmodule

`default_nettype wire

// ==== chipbus_pkg.sv ====
/*
 * shared bus definitions for the cpu side core
 * address and data types, cia register numbers, address map,
 * bridge state type and small per-cia lookup functions
 */
`default_nettype none

package chipbus_pkg;

	typedef logic [23:1] addr_t;	// cpu word address
	typedef logic [15:0] data_t;
	typedef logic [7:0]  byte_t;	// one cia data byte
	typedef logic [3:0]  cia_rs_t;	// cia register select

	// cia register numbers
	localparam cia_rs_t REG_PRA  = 4'd0;
	localparam cia_rs_t REG_DDRA = 4'd2;
	localparam cia_rs_t REG_TALO = 4'd4;
	localparam cia_rs_t REG_TAHI = 4'd5;
	localparam cia_rs_t REG_ICR  = 4'd13;
	localparam cia_rs_t REG_CRA  = 4'd14;

	// -------------------- address map
	localparam logic [11:0] CIA_A_BASE = 12'hbfe;	// odd bytes, low lane
	localparam logic [11:0] CIA_B_BASE = 12'hbfd;	// even bytes, high lane
	localparam logic [3:0]  CHIP_LIMIT = 4'h1;	// chip region 000000..1fffff

	localparam int NUM_CIA = 2;

	localparam logic [2:0] IPL_CIA_A = 3'd2;
	localparam logic [2:0] IPL_CIA_B = 3'd6;

	// bridge sequencer states
	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_WAIT_E,	// cia cycle, waiting for the e clock
		BUS_ACCESS,
		BUS_ACK,	// dtack driven
		BUS_RELEASE
	} bus_state_t;

	// -------------------- per-cia lookups, index 0 is cia a
	function automatic logic [11:0] cia_base(int idx);
		return (idx == 0) ? CIA_A_BASE : CIA_B_BASE;
	endfunction

	function automatic int cia_lane(int idx);
		return (idx == 0) ? 0 : 1;	// byte lane number
	endfunction

	function automatic logic [2:0] cia_ipl(int idx);
		return (idx == 0) ? IPL_CIA_A : IPL_CIA_B;
	endfunction

endpackage

`default_nettype wire

// ==== cia_bus_if.sv ====
/*
 * register bus between the address decoder, one cia
 * and the read merge
 */
`default_nettype none

interface cia_bus_if;
	import chipbus_pkg::*;

	logic    sel;	// one cycle access strobe
	logic    wr;
	cia_rs_t rs;
	byte_t   wdata;
	byte_t   rdata;	// held until the next sel
	logic    irq;

	modport decoder (output sel, wr, rs, wdata);

	modport cia (
		input  sel, wr, rs, wdata,
		output rdata, irq
	);

	modport merge (input rdata, irq);

endinterface

`default_nettype wire

// ==== cia_timer_port.sv ====
/*
 * one cia: timer a with latch, interrupt control
 * and an 8 bit data port with direction register
 */
`default_nettype none

module cia_timer_port (
	input  logic               clk,
	input  logic               reset,
	input  logic               eclk_tick,	// timer count enable
	cia_bus_if.cia             bus,
	input  chipbus_pkg::byte_t pa_in,
	output chipbus_pkg::byte_t pa_out,
	output chipbus_pkg::byte_t pa_dir
);
	import chipbus_pkg::*;

	byte_t       pra;
	byte_t       ddra;	// 1 = output
	logic [15:0] ta_latch;
	logic [15:0] ta_count;
	logic        ta_start;	// cra bit 0
	logic        ta_flag;
	logic        ta_under;
	logic        icr_mask;	// timer a enable, icr bit 0
	logic        wr_en;
	logic        rd_en;

	assign wr_en = bus.sel & bus.wr;
	assign rd_en = bus.sel & ~bus.wr;

	// -------------------- register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			pra      <= '0;
			ddra     <= '0;
			ta_latch <= 16'hffff;
			ta_start <= 1'b0;
			icr_mask <= 1'b0;
		end else if (wr_en) begin
			case (bus.rs)
				REG_PRA:  pra <= bus.wdata;
				REG_DDRA: ddra <= bus.wdata;
				REG_TALO: ta_latch[7:0] <= bus.wdata;
				REG_TAHI: ta_latch[15:8] <= bus.wdata;
				REG_ICR: begin
					if (bus.wdata[0])
						icr_mask <= bus.wdata[7];	// bit 7 picks set or clear mode
				end
				REG_CRA:  ta_start <= bus.wdata[0];
				default: ;
			endcase
		end
	end

	// -------------------- timer a
	assign ta_under = ta_start & eclk_tick & (ta_count == 16'h0000);

	always_ff @(posedge clk) begin
		if (reset)
			ta_count <= 16'hffff;
		else if (wr_en && bus.rs == REG_TAHI && !ta_start)
			ta_count <= {bus.wdata, ta_latch[7:0]};	// high byte write loads a stopped timer
		else if (ta_under)
			ta_count <= ta_latch;	// reload
		else if (ta_start && eclk_tick)
			ta_count <= ta_count - 16'd1;
	end

	// underflow wins over a clearing icr read in the same cycle
	always_ff @(posedge clk) begin
		if (reset)
			ta_flag <= 1'b0;
		else if (ta_under)
			ta_flag <= 1'b1;
		else if (rd_en && bus.rs == REG_ICR)
			ta_flag <= 1'b0;	// read clears
	end

	assign bus.irq = ta_flag & icr_mask;

	// -------------------- register reads
	always_ff @(posedge clk) begin
		if (reset) begin
			bus.rdata <= '0;
		end else if (rd_en) begin
			case (bus.rs)
				REG_PRA:  bus.rdata <= (pa_in & ~ddra) | (pra & ddra);	// pins where input
				REG_DDRA: bus.rdata <= ddra;
				REG_TALO: bus.rdata <= ta_count[7:0];
				REG_TAHI: bus.rdata <= ta_count[15:8];
				REG_ICR:  bus.rdata <= {bus.irq, 6'b000000, ta_flag};
				REG_CRA:  bus.rdata <= {7'b0000000, ta_start};
				default:  bus.rdata <= '0;
			endcase
		end
	end

	assign pa_out = pra;
	assign pa_dir = ddra;

endmodule

`default_nettype wire

// ==== compile.f ====
chipbus_pkg.sv
cia_bus_if.sv
cpu_bus_bridge.sv
address_decoder.sv
cia_timer_port.sv
chip_ram.sv
bus_read_merge.sv
minimig_core.sv
minimig_core_sva.sv
tb_minimig_core.sv

// ==== cpu_bus_bridge.sv ====
/*
 * 68000 style strobe/acknowledge sequencer
 * e clock alignment for cia cycles, delayed cpu reset
 */
`default_nettype none

module cpu_bus_bridge (
	input  logic       clk,
	input  logic       reset,
	input  logic       eclk_tick,	// one cycle pulse per e clock
	input  logic       cpu_as,
	input  logic       cpu_rw,	// high for read
	input  logic       cpu_uds,
	input  logic       cpu_lds,
	output logic       cpu_dtack,
	output logic       cpu_reset,
	input  logic       cia_cycle,	// from decoder
	output logic       strobe,
	output logic       wr,
	output logic [1:0] byte_en
);
	import chipbus_pkg::*;

	bus_state_t state;
	bus_state_t state_next;
	logic       rst_d1;
	logic       rst_d2;

	// -------------------- sequencer
	always_ff @(posedge clk) begin
		if (reset)
			state <= BUS_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			BUS_IDLE:
				if (cpu_as)
					state_next = cia_cycle ? BUS_WAIT_E : BUS_ACCESS;
			BUS_WAIT_E:
				if (eclk_tick)
					state_next = BUS_ACK;	// sel goes out this cycle
			BUS_ACCESS:
				state_next = BUS_ACK;
			BUS_ACK:
				if (!cpu_as)
					state_next = BUS_RELEASE;	// cpu ended the cycle
			BUS_RELEASE:
				state_next = BUS_IDLE;	// one idle gap before next cycle
			default:
				state_next = BUS_IDLE;
		endcase
	end

	// single access pulse, cia cycles aligned to the e clock
	assign strobe = (state == BUS_ACCESS) | ((state == BUS_WAIT_E) & eclk_tick);

	assign cpu_dtack = (state == BUS_ACK);	// held while as stays high
	assign wr        = ~cpu_rw;
	assign byte_en   = {cpu_uds, cpu_lds};	// [1] high lane, [0] low lane

	// -------------------- cpu reset stretch
	// two flops keep the cpu in reset a little past the system reset
	always_ff @(posedge clk) begin
		if (reset) begin
			rst_d1 <= 1'b1;
			rst_d2 <= 1'b1;
		end else begin
			rst_d1 <= 1'b0;
			rst_d2 <= rst_d1;
		end
	end

	assign cpu_reset = rst_d2;

endmodule

`default_nettype wire

// ==== minimig_core.sv ====
/*
 * cpu side core top: bus bridge, decoder, chip ram,
 * the cia pair and the read merge
 */
`default_nettype none

module minimig_core #(
	parameter  int CHIP_WORDS = 256,
	parameter  int NUM_CIA    = chipbus_pkg::NUM_CIA,
	localparam int RAM_AW     = $clog2(CHIP_WORDS)
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               eclk_tick,
	input  logic               cpu_as,
	input  logic               cpu_rw,
	input  logic               cpu_uds,
	input  logic               cpu_lds,
	input  chipbus_pkg::addr_t cpu_address,
	input  chipbus_pkg::data_t cpu_wdata,
	output chipbus_pkg::data_t cpu_data,
	output logic               cpu_dtack,
	output logic [2:0]         cpu_ipl,
	output logic               cpu_reset,
	output logic               ovl,
	input  chipbus_pkg::byte_t port_a_in,
	input  chipbus_pkg::byte_t port_b_in,
	output chipbus_pkg::byte_t port_a_out,
	output chipbus_pkg::byte_t port_b_out,
	output chipbus_pkg::byte_t port_a_dir,
	output chipbus_pkg::byte_t port_b_dir
);
	import chipbus_pkg::*;

	logic              strobe;
	logic              wr;
	logic [1:0]        byte_en;
	logic              cia_cycle;
	logic              ram_en;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_addr;
	logic [1:0]        ram_be;
	logic              ram_sel;
	data_t             ram_rdata;
	byte_t             port_in  [NUM_CIA];
	byte_t             port_out [NUM_CIA];
	byte_t             port_dir [NUM_CIA];

	cia_bus_if cia_bus [NUM_CIA] ();

	// -------------------- bus path
	cpu_bus_bridge u_bridge (
		.clk       (clk),
		.reset     (reset),
		.eclk_tick (eclk_tick),
		.cpu_as    (cpu_as),
		.cpu_rw    (cpu_rw),
		.cpu_uds   (cpu_uds),
		.cpu_lds   (cpu_lds),
		.cpu_dtack (cpu_dtack),
		.cpu_reset (cpu_reset),
		.cia_cycle (cia_cycle),
		.strobe    (strobe),
		.wr        (wr),
		.byte_en   (byte_en)
	);

	address_decoder #(
		.CHIP_WORDS (CHIP_WORDS),
		.NUM_CIA    (NUM_CIA)
	) u_decoder (
		.clk       (clk),
		.reset     (reset),
		.address   (cpu_address),
		.wdata     (cpu_wdata),
		.strobe    (strobe),
		.wr        (wr),
		.byte_en   (byte_en),
		.cia_cycle (cia_cycle),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_be    (ram_be),
		.cia       (cia_bus),
		.ovl       (ovl)
	);

	chip_ram #(
		.CHIP_WORDS (CHIP_WORDS)
	) u_chip_ram (
		.clk   (clk),
		.en    (ram_en),
		.we    (ram_we),
		.be    (ram_be),
		.addr  (ram_addr),
		.wdata (cpu_wdata),
		.rdata (ram_rdata)
	);

	// read source, latched with each access strobe
	always_ff @(posedge clk) begin
		if (reset)
			ram_sel <= 1'b0;
		else if (strobe)
			ram_sel <= ram_en & ~ram_we;	// chip read
	end

	// -------------------- cia pair
	for (genvar i = 0; i < NUM_CIA; i++) begin : g_cia
		cia_timer_port u_cia (
			.clk       (clk),
			.reset     (reset),
			.eclk_tick (eclk_tick),
			.bus       (cia_bus[i]),
			.pa_in     (port_in[i]),
			.pa_out    (port_out[i]),
			.pa_dir    (port_dir[i])
		);
	end

	bus_read_merge #(
		.NUM_CIA (NUM_CIA)
	) u_merge (
		.cias      (cia_bus),
		.ram_rdata (ram_rdata),
		.ram_sel   (ram_sel),
		.cpu_data  (cpu_data),
		.cpu_ipl   (cpu_ipl)
	);

	// port pins by cia index, 0 is cia a
	assign port_in[0] = port_a_in;
	assign port_in[1] = port_b_in;
	assign port_a_out = port_out[0];
	assign port_b_out = port_out[1];
	assign port_a_dir = port_dir[0];
	assign port_b_dir = port_dir[1];

endmodule

`default_nettype wire

// ==== minimig_core_sva.sv ====
/*
 * concurrent checks on the cpu handshake, chip access latency
 * and the interrupt level in reset, bound into the core top
 */
`default_nettype none

module minimig_core_sva (
	input logic       clk,
	input logic       reset,
	input logic       cpu_as,
	input logic       cpu_dtack,
	input logic       cia_cycle,	// decoder output inside the core
	input logic [2:0] cpu_ipl
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;	// failed assertions so far

	// dtack may outlive as only by the release cycle
	a_dtack_needs_as: assert property (@(posedge clk) disable iff (reset)
		cpu_dtack |-> cpu_as || $past(cpu_as))
		else begin
			$error("dtack high without address strobe");
			fail_count++;
		end

	a_dtack_release: assert property (@(posedge clk) disable iff (reset)
		$fell(cpu_as) && cpu_dtack |=> !cpu_dtack)
		else begin
			$error("dtack not dropped the cycle after as fell");
			fail_count++;
		end

	a_ipl_reset: assert property (@(posedge clk)
		reset |=> cpu_ipl == 3'd0)
		else begin
			$error("interrupt level not zero in reset");
			fail_count++;
		end

	// chip and unmapped cycles, no e clock wait
	a_chip_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(cpu_as) && !cia_cycle |-> ##2 $rose(cpu_dtack))
		else begin
			$error("chip access dtack not two cycles after as");
			fail_count++;
		end

endmodule

bind minimig_core minimig_core_sva u_sva (
	.clk       (clk),
	.reset     (reset),
	.cpu_as    (cpu_as),
	.cpu_dtack (cpu_dtack),
	.cia_cycle (cia_cycle),
	.cpu_ipl   (cpu_ipl)
);

`default_nettype wire

// ==== tb_minimig_core.sv ====
/*
 * directed testbench for the cpu side core
 * clock, reset and e clock tick, bus cycle tasks,
 * typed compare tasks and the test sequence
 */
`default_nettype none

module tb_minimig_core;
	timeunit 1ns;
	timeprecision 100ps;

	import chipbus_pkg::*;

	localparam int CHIP_WORDS    = 256;
	localparam int DTACK_TIMEOUT = 40;	// cycles, more than one e clock period
	localparam int IRQ_TIMEOUT   = 400;

	logic       clk;
	logic       reset;
	logic       eclk_tick;
	logic       cpu_as;
	logic       cpu_rw;
	logic       cpu_uds;
	logic       cpu_lds;
	addr_t      cpu_address;
	data_t      cpu_wdata;
	data_t      cpu_data;
	logic       cpu_dtack;
	logic [2:0] cpu_ipl;
	logic       cpu_reset;
	logic       ovl;
	byte_t      port_a_in;
	byte_t      port_b_in;
	byte_t      port_a_out;
	byte_t      port_b_out;
	byte_t      port_a_dir;
	byte_t      port_b_dir;

	integer seed;
	int     e_count;
	int     data_errors;
	int     ipl_errors;
	int     other_errors;

	minimig_core #(
		.CHIP_WORDS (CHIP_WORDS)
	) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// e clock tick, one pulse every ten cycles
	always @(posedge clk) begin
		if (e_count == 9) begin
			e_count   <= 0;
			eclk_tick <= 1'b1;
		end else begin
			e_count   <= e_count + 1;
			eclk_tick <= 1'b0;
		end
	end

	// -------------------- compare tasks
	task automatic check_data(input string name, input data_t got, input data_t expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, expected);
			data_errors++;
		end
	endtask

	task automatic check_ipl(input string name, input logic [2:0] got,
			input logic [2:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, expected);
			ipl_errors++;
		end
	endtask

	// -------------------- bus cycles
	// word address of a cia register, register number in bits 11..8
	function automatic addr_t cia_reg_addr(input int idx, input cia_rs_t rs);
		logic [23:0] byte_addr;
		byte_addr = {(idx == 0) ? 12'hbfe : 12'hbfd, rs, 8'h01};
		return byte_addr[23:1];
	endfunction

	function automatic logic [1:0] lane_be(input int idx);
		return (idx == 0) ? 2'b01 : 2'b10;	// cia a low byte, cia b high byte
	endfunction

	task automatic wait_dtack(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (!cpu_dtack && cycles < DTACK_TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (!cpu_dtack) begin
			$display("no dtack within %0d cycles of address strobe", cycles);
			other_errors++;
		end
	endtask

	task automatic release_bus();
		int cycles;
		@(posedge clk);
		cpu_as  <= 1'b0;
		cpu_uds <= 1'b0;
		cpu_lds <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (cpu_dtack && cycles < DTACK_TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (cpu_dtack) begin
			$display("dtack still high %0d cycles after as was dropped", cycles);
			other_errors++;
		end
	endtask

	task automatic bus_write(input addr_t addr, input data_t data, input logic [1:0] be);
		int cycles;
		@(posedge clk);
		cpu_address <= addr;
		cpu_wdata   <= data;
		cpu_rw      <= 1'b0;
		cpu_uds     <= be[1];
		cpu_lds     <= be[0];
		cpu_as      <= 1'b1;
		wait_dtack(cycles);
		release_bus();
	endtask

	task automatic bus_read(input addr_t addr, input logic [1:0] be, output data_t data,
			output int cycles);
		@(posedge clk);
		cpu_address <= addr;
		cpu_rw      <= 1'b1;
		cpu_uds     <= be[1];
		cpu_lds     <= be[0];
		cpu_as      <= 1'b1;
		wait_dtack(cycles);
		data = cpu_data;
		@(negedge clk);	// cpu keeps as one more cycle
		check_data("cpu_dtack held", data_t'(cpu_dtack), 16'h0001);
		check_data("cpu_data held", cpu_data, data);
		release_bus();
	endtask

	task automatic cia_write(input int idx, input cia_rs_t rs, input byte_t value);
		bus_write(cia_reg_addr(idx, rs), {value, value}, lane_be(idx));
	endtask

	task automatic cia_read(input int idx, input cia_rs_t rs, output byte_t value);
		data_t word;
		int    cycles;
		bus_read(cia_reg_addr(idx, rs), lane_be(idx), word, cycles);
		value = (idx == 0) ? word[7:0] : word[15:8];	// own lane only
	endtask

	task automatic wait_ipl(input logic [2:0] level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (cpu_ipl !== level && cycles < IRQ_TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (cpu_ipl !== level) begin
			$display("interrupt level %0d not reached within %0d cycles", level, cycles);
			other_errors++;
		end
	endtask

	// -------------------- tests
	task automatic test_reset();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (cpu_reset && cycles < 10) begin	// cpu reset outlasts the system reset
			cycles++;
			@(negedge clk);
		end
		if (cycles != 2) begin
			$display("cpu reset held %0d cycles after reset fell, expected 2", cycles);
			other_errors++;
		end
		check_data("cpu_dtack", data_t'(cpu_dtack), 16'h0000);
		check_ipl("cpu_ipl", cpu_ipl, 3'd0);
		check_data("ovl", data_t'(ovl), 16'h0001);
		check_data("port_a_dir", data_t'(port_a_dir), 16'h0000);
		check_data("port_b_dir", data_t'(port_b_dir), 16'h0000);
	endtask

	task automatic test_chip_ram();
		addr_t addr;
		addr_t mirror;
		data_t word;
		data_t expected;
		data_t got;
		byte_t value;
		logic  high_lane;
		int    cycles;
		for (int i = 0; i < 8; i++) begin
			addr = addr_t'($random(seed));
			addr[23:21] = 3'b000;	// below byte address 200000
			word = data_t'($random(seed));
			value = byte_t'($random(seed));
			high_lane = ($random(seed) & 1) != 0;
			bus_write(addr, word, 2'b11);
			bus_write(addr, {value, value}, high_lane ? 2'b10 : 2'b01);
			expected = high_lane ? {value, word[7:0]} : {word[15:8], value};
			bus_read(addr, 2'b11, got, cycles);
			check_data("cpu_data", got, expected);
			if (cycles != 2) begin
				$display("chip read took %0d cycles to dtack, expected 2", cycles);
				other_errors++;
			end
			mirror = addr;
			mirror[20] = ~addr[20];	// same ram word one megabyte away
			bus_read(mirror, 2'b11, got, cycles);
			check_data("cpu_data mirror", got, expected);
		end
		bus_read(addr_t'(24'he00000 >> 1), 2'b11, got, cycles);	// nothing mapped here
		check_data("cpu_data unmapped", got, 16'h0000);
	endtask

	task automatic test_overlay();
		cia_write(1, REG_PRA, 8'h00);
		check_data("ovl after cia b write", data_t'(ovl), 16'h0001);
		cia_write(0, REG_PRA, 8'h00);
		check_data("ovl after cia a write", data_t'(ovl), 16'h0000);
	endtask

	task automatic test_data_port(input int idx);
		byte_t ddr;
		byte_t pra;
		byte_t pin;
		byte_t got;
		byte_t expected;
		ddr = byte_t'($random(seed));
		pra = byte_t'($random(seed));
		pin = byte_t'($random(seed));
		cia_write(idx, REG_DDRA, ddr);
		cia_write(idx, REG_PRA, pra);
		if (idx == 0) begin
			check_data("port_a_out", data_t'(port_a_out), data_t'(pra));
			check_data("port_a_dir", data_t'(port_a_dir), data_t'(ddr));
		end else begin
			check_data("port_b_out", data_t'(port_b_out), data_t'(pra));
			check_data("port_b_dir", data_t'(port_b_dir), data_t'(ddr));
		end
		@(posedge clk);
		if (idx == 0)
			port_a_in <= pin;
		else
			port_b_in <= pin;
		cia_read(idx, REG_PRA, got);
		// output latch where the direction bit is set, else the pin
		for (int b = 0; b < 8; b++)
			expected[b] = ddr[b] ? pra[b] : pin[b];
		check_data("cpu_data pra", data_t'(got), data_t'(expected));
	endtask

	task automatic test_timer_irq(input int idx, input logic [2:0] level);
		byte_t got;
		cia_write(idx, REG_TALO, 8'd3);
		cia_write(idx, REG_TAHI, 8'd0);	// loads the stopped counter
		cia_write(idx, REG_ICR, 8'h81);	// set mask bit 0
		cia_write(idx, REG_CRA, 8'h01);
		wait_ipl(level);
		check_ipl("cpu_ipl timer", cpu_ipl, level);
		cia_read(idx, REG_ICR, got);
		check_data("icr", data_t'(got), 16'h0081);
		check_ipl("cpu_ipl after icr read", cpu_ipl, 3'd0);
		cia_write(idx, REG_CRA, 8'h00);
	endtask

	task automatic test_both_pending();
		byte_t got;
		cia_write(0, REG_CRA, 8'h01);
		wait_ipl(3'd2);
		cia_write(1, REG_CRA, 8'h01);
		wait_ipl(3'd6);	// cia a flag still set underneath
		check_ipl("cpu_ipl both pending", cpu_ipl, 3'd6);
		cia_write(0, REG_CRA, 8'h00);
		cia_write(1, REG_CRA, 8'h00);
		cia_read(1, REG_ICR, got);
		check_data("icr cia b", data_t'(got), 16'h0081);
		check_ipl("cpu_ipl cia a left", cpu_ipl, 3'd2);
		cia_read(0, REG_ICR, got);
		check_data("icr cia a", data_t'(got), 16'h0081);
		check_ipl("cpu_ipl none left", cpu_ipl, 3'd0);
	endtask

	// -------------------- sequence
	initial begin
		seed         = 32'h687134bc;
		data_errors  = 0;
		ipl_errors   = 0;
		other_errors = 0;
		e_count      = 0;
		reset        = 1'b1;
		eclk_tick    = 1'b0;
		cpu_as       = 1'b0;
		cpu_rw       = 1'b1;
		cpu_uds      = 1'b0;
		cpu_lds      = 1'b0;
		cpu_address  = '0;
		cpu_wdata    = '0;
		port_a_in    = '0;
		port_b_in    = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_chip_ram();	// before any cia read, unmapped reads see zero
		test_overlay();
		test_data_port(0);
		test_data_port(1);
		test_timer_irq(0, 3'd2);
		test_timer_irq(1, 3'd6);
		test_both_pending();
		$display("errors: data %0d, ipl %0d, other %0d, assertion %0d", data_errors,
			ipl_errors, other_errors, DUT.u_sva.fail_count);
		if (data_errors + ipl_errors + other_errors + DUT.u_sva.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
